//--- logic/subsys_cfg.svh
`ifndef SUBSYS_CFG_SVH
`define SUBSYS_CFG_SVH

// ram depth in 32-bit words
`define SUBSYS_RAM_WORDS 1024

// peripheral window, 4 KiB starting at the base
`define SUBSYS_PERIPH_BASE 32'h1000_0000
`define SUBSYS_PERIPH_SPAN 32'h0000_1000

// register byte offsets inside the peripheral window
`define SUBSYS_STDOUT_OFS    12'h000
`define SUBSYS_EXIT_OFS      12'h004
`define SUBSYS_TIMER_CMP_OFS 12'h008

`endif

//--- logic/bus_pkg.sv
package bus_pkg;

  // byte address, data word and byte lanes of the shared wishbone bus
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  sel_t;

  // which port owns the shared bus
  typedef enum logic {
    MASTER_FETCH,
    MASTER_DATA
  } master_e;

  // replace the bytes of old_word whose lane is selected
  function automatic data_t byte_merge(data_t old_word, data_t new_word, sel_t sel);
    data_t merged;
    merged = old_word;
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) begin
        merged[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return merged;
  endfunction

endpackage

//--- logic/periph_pkg.sv
package periph_pkg;

  // target of a decoded address
  typedef enum logic [1:0] {
    REGION_RAM,
    REGION_PERIPH,
    REGION_NONE
  } region_e;

  // registers of the test peripheral
  typedef enum logic [1:0] {
    REG_STDOUT,
    REG_EXIT,
    REG_TIMER_CMP,
    REG_NONE
  } periph_reg_e;

  // free-running timer count, also the width of the compare register
  typedef logic [31:0] timer_t;

endpackage

//--- logic/bus_interconnect.sv
`timescale 1ns/1ps
`include "subsys_cfg.svh"

module bus_interconnect (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     fetch_cyc_i,
  input  logic                     fetch_stb_i,
  input  bus_pkg::addr_t           fetch_adr_i,
  output bus_pkg::data_t           fetch_dat_o,
  output logic                     fetch_ack_o,
  input  logic                     data_cyc_i,
  input  logic                     data_stb_i,
  input  logic                     data_we_i,
  input  bus_pkg::addr_t           data_adr_i,
  input  bus_pkg::data_t           data_dat_i,
  input  bus_pkg::sel_t            data_sel_i,
  output bus_pkg::data_t           data_dat_o,
  output logic                     data_ack_o,
  output logic                     ram_stb_o,
  output logic                     ram_we_o,
  output bus_pkg::addr_t           ram_adr_o,
  output bus_pkg::data_t           ram_dat_o,
  output bus_pkg::sel_t            ram_sel_o,
  input  bus_pkg::data_t           ram_dat_i,
  input  logic                     ram_ack_i,
  output logic                     per_stb_o,
  output logic                     per_we_o,
  output bus_pkg::addr_t           per_adr_o,
  output bus_pkg::data_t           per_dat_o,
  output bus_pkg::sel_t            per_sel_o,
  input  bus_pkg::data_t           per_dat_i,
  input  logic                     per_ack_i
);

  logic                busy_q;
  bus_pkg::master_e    grant_q;
  bus_pkg::master_e    last_q;
  bus_pkg::master_e    next_grant;
  logic                none_ack_q;
  logic                fetch_req;
  logic                data_req;
  logic                req_stb;
  logic                req_we;
  bus_pkg::addr_t      req_adr;
  bus_pkg::data_t      req_dat;
  bus_pkg::sel_t       req_sel;
  periph_pkg::region_e region;
  logic                slave_ack;
  bus_pkg::data_t      slave_dat;

  assign fetch_req = fetch_cyc_i & fetch_stb_i;
  assign data_req  = data_cyc_i & data_stb_i;

  // round robin, the port not served last wins a tie
  always_comb begin
    if (fetch_req && data_req) begin
      next_grant = (last_q == bus_pkg::MASTER_FETCH) ? bus_pkg::MASTER_DATA
                                                     : bus_pkg::MASTER_FETCH;
    end else if (fetch_req) begin
      next_grant = bus_pkg::MASTER_FETCH;
    end else begin
      next_grant = bus_pkg::MASTER_DATA;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_q  <= 1'b0;
      grant_q <= bus_pkg::MASTER_FETCH;
      last_q  <= bus_pkg::MASTER_DATA;
    end else if (!busy_q) begin
      if (fetch_req || data_req) begin
        busy_q  <= 1'b1;
        grant_q <= next_grant;
      end
    end else if (slave_ack) begin
      // one idle cycle follows so the finished port can drop its strobe
      busy_q <= 1'b0;
      last_q <= grant_q;
    end
  end

  // request of the granted port, fetch reads use all byte lanes
  always_comb begin
    if (grant_q == bus_pkg::MASTER_FETCH) begin
      req_stb = fetch_req;
      req_we  = 1'b0;
      req_adr = fetch_adr_i;
      req_dat = '0;
      req_sel = '1;
    end else begin
      req_stb = data_req;
      req_we  = data_we_i;
      req_adr = data_adr_i;
      req_dat = data_dat_i;
      req_sel = data_sel_i;
    end
  end

  always_comb begin
    if (req_adr < 32'(`SUBSYS_RAM_WORDS * 4)) begin
      region = periph_pkg::REGION_RAM;
    end else if (req_adr >= `SUBSYS_PERIPH_BASE &&
                 req_adr < `SUBSYS_PERIPH_BASE + `SUBSYS_PERIPH_SPAN) begin
      region = periph_pkg::REGION_PERIPH;
    end else begin
      region = periph_pkg::REGION_NONE;
    end
  end

  assign ram_stb_o = busy_q & req_stb & (region == periph_pkg::REGION_RAM);
  assign ram_we_o  = req_we;
  assign ram_adr_o = req_adr;
  assign ram_dat_o = req_dat;
  assign ram_sel_o = req_sel;
  assign per_stb_o = busy_q & req_stb & (region == periph_pkg::REGION_PERIPH);
  assign per_we_o  = req_we;
  assign per_adr_o = req_adr;
  assign per_dat_o = req_dat;
  assign per_sel_o = req_sel;

  // unmapped accesses complete here with the same one-cycle latency
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      none_ack_q <= 1'b0;
    end else begin
      none_ack_q <= busy_q & req_stb & (region == periph_pkg::REGION_NONE) & ~none_ack_q;
    end
  end

  always_comb begin
    case (region)
      periph_pkg::REGION_RAM: begin
        slave_ack = ram_ack_i;
        slave_dat = ram_dat_i;
      end
      periph_pkg::REGION_PERIPH: begin
        slave_ack = per_ack_i;
        slave_dat = per_dat_i;
      end
      default: begin
        slave_ack = none_ack_q;
        slave_dat = '0;
      end
    endcase
  end

  assign fetch_ack_o = busy_q & slave_ack & (grant_q == bus_pkg::MASTER_FETCH);
  assign data_ack_o  = busy_q & slave_ack & (grant_q == bus_pkg::MASTER_DATA);
  assign fetch_dat_o = (busy_q && grant_q == bus_pkg::MASTER_FETCH) ? slave_dat : '0;
  assign data_dat_o  = (busy_q && grant_q == bus_pkg::MASTER_DATA) ? slave_dat : '0;

  // the granted port keeps its request up until the slave acks
  granted_req_held_a: assert property (@(posedge clk_i) disable iff (reset_i)
    (busy_q && !slave_ack) |-> req_stb);

  fetch_ack_cyc_a: assert property (@(posedge clk_i) disable iff (reset_i)
    fetch_ack_o |-> fetch_cyc_i);

  data_ack_cyc_a: assert property (@(posedge clk_i) disable iff (reset_i)
    data_ack_o |-> data_cyc_i);

endmodule

//--- logic/sim_ram.sv
`timescale 1ns/1ps
`include "subsys_cfg.svh"

module sim_ram (
  input  logic           clk_i,
  input  logic           reset_i,
  input  logic           stb_i,
  input  logic           we_i,
  input  bus_pkg::addr_t adr_i,
  input  bus_pkg::data_t dat_i,
  input  bus_pkg::sel_t  sel_i,
  output bus_pkg::data_t dat_o,
  output logic           ack_o
);

  localparam int IDX_W = $clog2(`SUBSYS_RAM_WORDS);

  bus_pkg::data_t   mem_q [`SUBSYS_RAM_WORDS];
  logic [IDX_W-1:0] idx;
  logic             ack_q;

  // word index, byte offset bits are ignored
  assign idx = adr_i[IDX_W+1:2];

  // ack one cycle after the strobe, then drop it
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= stb_i & ~ack_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (stb_i && !ack_q) begin
      dat_o <= mem_q[idx];
    end
    // write data is taken in the ack cycle
    if (stb_i && ack_q && we_i) begin
      mem_q[idx] <= bus_pkg::byte_merge(mem_q[idx], dat_i, sel_i);
    end
  end

  assign ack_o = ack_q;

  adr_in_range_a: assert property (@(posedge clk_i) disable iff (reset_i)
    stb_i |-> ((adr_i >> 2) < `SUBSYS_RAM_WORDS));

endmodule

//--- logic/test_periph.sv
`timescale 1ns/1ps
`include "subsys_cfg.svh"

module test_periph (
  input  logic           clk_i,
  input  logic           reset_i,
  input  logic           stb_i,
  input  logic           we_i,
  input  bus_pkg::addr_t adr_i,
  input  bus_pkg::data_t dat_i,
  input  bus_pkg::sel_t  sel_i,
  output bus_pkg::data_t dat_o,
  output logic           ack_o,
  output logic [7:0]     stdout_char_o,
  output logic           stdout_valid_o,
  output bus_pkg::data_t exit_value_o,
  output logic           exit_valid_o,
  output logic           tests_passed_o,
  output logic           tests_failed_o,
  output logic           irq_timer_o
);

  periph_pkg::periph_reg_e reg_hit;
  periph_pkg::timer_t      timer_q;
  periph_pkg::timer_t      cmp_q;
  logic                    ack_q;
  logic                    wr_en;

  // only the offset inside the window matters here
  always_comb begin
    case (adr_i[11:0])
      `SUBSYS_STDOUT_OFS:    reg_hit = periph_pkg::REG_STDOUT;
      `SUBSYS_EXIT_OFS:      reg_hit = periph_pkg::REG_EXIT;
      `SUBSYS_TIMER_CMP_OFS: reg_hit = periph_pkg::REG_TIMER_CMP;
      default:               reg_hit = periph_pkg::REG_NONE;
    endcase
  end

  // registers update in the ack cycle, so once per transfer
  assign wr_en = stb_i & we_i & ack_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ack_q          <= 1'b0;
      timer_q        <= '0;
      cmp_q          <= '0;
      stdout_valid_o <= 1'b0;
      exit_valid_o   <= 1'b0;
      tests_passed_o <= 1'b0;
      tests_failed_o <= 1'b0;
      irq_timer_o    <= 1'b0;
    end else begin
      ack_q          <= stb_i & ~ack_q;
      timer_q        <= timer_q + 1'b1;
      stdout_valid_o <= wr_en && (reg_hit == periph_pkg::REG_STDOUT) && sel_i[0];
      if (wr_en && reg_hit == periph_pkg::REG_EXIT) begin
        exit_valid_o <= 1'b1;
        if (dat_i == '0) begin
          tests_passed_o <= 1'b1;
        end else begin
          tests_failed_o <= 1'b1;
        end
      end
      if (wr_en && reg_hit == periph_pkg::REG_TIMER_CMP) begin
        cmp_q <= bus_pkg::byte_merge(cmp_q, dat_i, sel_i);
      end
      // a zero compare value disables the interrupt
      irq_timer_o <= (cmp_q != '0) && (timer_q >= cmp_q);
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en && reg_hit == periph_pkg::REG_STDOUT) begin
      stdout_char_o <= dat_i[7:0];
    end
    if (wr_en && reg_hit == periph_pkg::REG_EXIT) begin
      exit_value_o <= dat_i;
    end
    if (stb_i && !ack_q) begin
      case (reg_hit)
        periph_pkg::REG_TIMER_CMP: dat_o <= cmp_q;
        periph_pkg::REG_EXIT:      dat_o <= exit_value_o;
        default:                   dat_o <= '0;
      endcase
    end
  end

  assign ack_o = ack_q;

endmodule

//--- logic/mem_subsystem.sv
`timescale 1ns/1ps

module mem_subsystem (
  input  logic           clk_i,
  input  logic           reset_i,
  input  logic           fetch_cyc_i,
  input  logic           fetch_stb_i,
  input  bus_pkg::addr_t fetch_adr_i,
  output bus_pkg::data_t fetch_dat_o,
  output logic           fetch_ack_o,
  input  logic           data_cyc_i,
  input  logic           data_stb_i,
  input  logic           data_we_i,
  input  bus_pkg::addr_t data_adr_i,
  input  bus_pkg::data_t data_dat_i,
  input  bus_pkg::sel_t  data_sel_i,
  output bus_pkg::data_t data_dat_o,
  output logic           data_ack_o,
  output logic [7:0]     stdout_char_o,
  output logic           stdout_valid_o,
  output bus_pkg::data_t exit_value_o,
  output logic           exit_valid_o,
  output logic           tests_passed_o,
  output logic           tests_failed_o,
  output logic           irq_timer_o
);

  // interconnect to ram
  logic           ram_stb;
  logic           ram_we;
  bus_pkg::addr_t ram_adr;
  bus_pkg::data_t ram_dat_w;
  bus_pkg::sel_t  ram_sel;
  bus_pkg::data_t ram_dat_r;
  logic           ram_ack;

  // interconnect to peripherals
  logic           per_stb;
  logic           per_we;
  bus_pkg::addr_t per_adr;
  bus_pkg::data_t per_dat_w;
  bus_pkg::sel_t  per_sel;
  bus_pkg::data_t per_dat_r;
  logic           per_ack;

  bus_interconnect u_interconnect (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .fetch_cyc_i(fetch_cyc_i),
    .fetch_stb_i(fetch_stb_i),
    .fetch_adr_i(fetch_adr_i),
    .fetch_dat_o(fetch_dat_o),
    .fetch_ack_o(fetch_ack_o),
    .data_cyc_i (data_cyc_i),
    .data_stb_i (data_stb_i),
    .data_we_i  (data_we_i),
    .data_adr_i (data_adr_i),
    .data_dat_i (data_dat_i),
    .data_sel_i (data_sel_i),
    .data_dat_o (data_dat_o),
    .data_ack_o (data_ack_o),
    .ram_stb_o  (ram_stb),
    .ram_we_o   (ram_we),
    .ram_adr_o  (ram_adr),
    .ram_dat_o  (ram_dat_w),
    .ram_sel_o  (ram_sel),
    .ram_dat_i  (ram_dat_r),
    .ram_ack_i  (ram_ack),
    .per_stb_o  (per_stb),
    .per_we_o   (per_we),
    .per_adr_o  (per_adr),
    .per_dat_o  (per_dat_w),
    .per_sel_o  (per_sel),
    .per_dat_i  (per_dat_r),
    .per_ack_i  (per_ack)
  );

  sim_ram u_ram (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .stb_i  (ram_stb),
    .we_i   (ram_we),
    .adr_i  (ram_adr),
    .dat_i  (ram_dat_w),
    .sel_i  (ram_sel),
    .dat_o  (ram_dat_r),
    .ack_o  (ram_ack)
  );

  test_periph u_periph (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .stb_i         (per_stb),
    .we_i          (per_we),
    .adr_i         (per_adr),
    .dat_i         (per_dat_w),
    .sel_i         (per_sel),
    .dat_o         (per_dat_r),
    .ack_o         (per_ack),
    .stdout_char_o (stdout_char_o),
    .stdout_valid_o(stdout_valid_o),
    .exit_value_o  (exit_value_o),
    .exit_valid_o  (exit_valid_o),
    .tests_passed_o(tests_passed_o),
    .tests_failed_o(tests_failed_o),
    .irq_timer_o   (irq_timer_o)
  );

endmodule

//--- tests/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 2
) (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // reset drops a little after the edge, like the other stimulus
  initial begin
    reset_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #2 reset_o = 1'b0;
  end

endmodule

//--- tests/subsys_tb.sv
`timescale 1ns/1ps
`include "subsys_cfg.svh"

module subsys_tb;

  localparam int CLK_NS     = 40;
  localparam int DRIVE_NS   = 2;
  localparam int CONT_N     = 12;
  localparam int CONT_XFERS = 4 * CONT_N;

  localparam bus_pkg::addr_t STDOUT_ADR = `SUBSYS_PERIPH_BASE + `SUBSYS_STDOUT_OFS;
  localparam bus_pkg::addr_t EXIT_ADR   = `SUBSYS_PERIPH_BASE + `SUBSYS_EXIT_OFS;
  localparam bus_pkg::addr_t CMP_ADR    = `SUBSYS_PERIPH_BASE + `SUBSYS_TIMER_CMP_OFS;

  typedef enum logic [2:0] {
    CHK_NONE, CHK_READ, CHK_STDOUT, CHK_EXIT_FAIL,
    CHK_RESET, CHK_EXIT_PASS, CHK_IRQ_SET, CHK_IRQ_CLEAR
  } kind_e;

  typedef struct packed {
    bus_pkg::master_e port;
    logic             we;
    bus_pkg::addr_t   adr;
    bus_pkg::data_t   dat;
    bus_pkg::sel_t    sel;
    kind_e            kind;
    bus_pkg::data_t   exp;
  } entry_t;

  logic           clk;
  logic           gen_reset;
  logic           rerun_reset;
  logic           reset;
  logic           fetch_cyc;
  logic           fetch_stb;
  bus_pkg::addr_t fetch_adr;
  bus_pkg::data_t fetch_dat_r;
  logic           fetch_ack;
  logic           data_cyc;
  logic           data_stb;
  logic           data_we;
  bus_pkg::addr_t data_adr;
  bus_pkg::data_t data_dat_w;
  bus_pkg::sel_t  data_sel;
  bus_pkg::data_t data_dat_r;
  logic           data_ack;
  logic [7:0]     stdout_char;
  logic           stdout_valid;
  bus_pkg::data_t exit_value;
  logic           exit_valid;
  logic           tests_passed;
  logic           tests_failed;
  logic           irq_timer;

  entry_t         table_q[$];
  bus_pkg::addr_t known_adr[$];
  bus_pkg::data_t known_dat[$];
  logic [31:0]    lfsr_q;
  int             error_count;
  int             test_count;
  int             bad_tests;
  longint         watchdog_ns;

  assign reset = gen_reset | rerun_reset;

  tb_clock_gen #(.PERIOD_NS(CLK_NS), .RESET_CYCLES(2)) u_clock_gen (
    .clk_o  (clk),
    .reset_o(gen_reset)
  );

  mem_subsystem u_mem_subsystem (
    .clk_i(clk), .reset_i(reset),
    .fetch_cyc_i(fetch_cyc), .fetch_stb_i(fetch_stb), .fetch_adr_i(fetch_adr),
    .fetch_dat_o(fetch_dat_r), .fetch_ack_o(fetch_ack),
    .data_cyc_i(data_cyc), .data_stb_i(data_stb), .data_we_i(data_we),
    .data_adr_i(data_adr), .data_dat_i(data_dat_w), .data_sel_i(data_sel),
    .data_dat_o(data_dat_r), .data_ack_o(data_ack),
    .stdout_char_o(stdout_char), .stdout_valid_o(stdout_valid),
    .exit_value_o(exit_value), .exit_valid_o(exit_valid),
    .tests_passed_o(tests_passed), .tests_failed_o(tests_failed),
    .irq_timer_o(irq_timer)
  );

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      v = {v[30:0], lfsr_q[31]};
      lfsr_q = lfsr_step(lfsr_q);
    end
    return v;
  endfunction

  task automatic check_word(input string what, input bus_pkg::data_t got,
                            input bus_pkg::data_t exp);
    if (got !== exp) begin
      $display("error at %0d ns: %s, got %h expected %h", $time, what, got, exp);
      error_count++;
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("error at %0d ns: %s, got %b expected %b", $time, what, got, exp);
      error_count++;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    test_count++;
    if (error_count == errs_before) begin
      $display("test %0d %s: ok", test_count, name);
    end else begin
      bad_tests++;
      $display("test %0d %s: %0d errors", test_count, name, error_count - errs_before);
    end
  endtask

  task automatic add_entry(input bus_pkg::master_e port, input logic we,
                           input bus_pkg::addr_t adr, input bus_pkg::data_t dat,
                           input bus_pkg::sel_t sel, input kind_e kind,
                           input bus_pkg::data_t exp);
    entry_t e;
    e.port = port;
    e.we   = we;
    e.adr  = adr;
    e.dat  = dat;
    e.sel  = sel;
    e.kind = kind;
    e.exp  = exp;
    table_q.push_back(e);
  endtask

  // each transfer starts just after an edge and holds stb through the ack edge
  task automatic fetch_read(input bus_pkg::addr_t adr, output bus_pkg::data_t dat);
    @(posedge clk);
    #DRIVE_NS;
    fetch_cyc = 1'b1;
    fetch_stb = 1'b1;
    fetch_adr = adr;
    do @(negedge clk); while (fetch_ack !== 1'b1);
    dat = fetch_dat_r;
    @(posedge clk);
    #DRIVE_NS;
    fetch_cyc = 1'b0;
    fetch_stb = 1'b0;
  endtask

  task automatic data_xfer(input logic we, input bus_pkg::addr_t adr,
                           input bus_pkg::data_t wdat, input bus_pkg::sel_t sel,
                           output bus_pkg::data_t rdat);
    @(posedge clk);
    #DRIVE_NS;
    data_cyc   = 1'b1;
    data_stb   = 1'b1;
    data_we    = we;
    data_adr   = adr;
    data_dat_w = wdat;
    data_sel   = sel;
    do @(negedge clk); while (data_ack !== 1'b1);
    rdat = data_dat_r;
    @(posedge clk);
    #DRIVE_NS;
    data_cyc = 1'b0;
    data_stb = 1'b0;
    data_we  = 1'b0;
  endtask

  task automatic build_table();
    // byte merges into ram, then the fetch port reads them back
    add_entry(bus_pkg::MASTER_DATA, 1'b1, 32'h40, 32'h1122_3344, 4'hf, CHK_NONE, '0);
    add_entry(bus_pkg::MASTER_DATA, 1'b1, 32'h40, 32'haabb_ccdd, 4'b0101, CHK_NONE, '0);
    add_entry(bus_pkg::MASTER_DATA, 1'b0, 32'h40, '0, 4'hf, CHK_READ, 32'h11bb_33dd);
    add_entry(bus_pkg::MASTER_DATA, 1'b1, 32'h44, 32'hdead_beef, 4'hf, CHK_NONE, '0);
    add_entry(bus_pkg::MASTER_DATA, 1'b1, 32'h44, 32'h5500_0000, 4'b1000, CHK_NONE, '0);
    add_entry(bus_pkg::MASTER_DATA, 1'b0, 32'h44, '0, 4'hf, CHK_READ, 32'h55ad_beef);
    add_entry(bus_pkg::MASTER_DATA, 1'b1, 32'h80, 32'ha5a5_5a5a, 4'hf, CHK_NONE, '0);
    add_entry(bus_pkg::MASTER_FETCH, 1'b0, 32'h40, '0, 4'hf, CHK_READ, 32'h11bb_33dd);
    add_entry(bus_pkg::MASTER_FETCH, 1'b0, 32'h44, '0, 4'hf, CHK_READ, 32'h55ad_beef);
    add_entry(bus_pkg::MASTER_FETCH, 1'b0, 32'h80, '0, 4'hf, CHK_READ, 32'ha5a5_5a5a);
    // unmapped holes read as zero
    add_entry(bus_pkg::MASTER_FETCH, 1'b0, 32'h2000_0000, '0, 4'hf, CHK_READ, '0);
    add_entry(bus_pkg::MASTER_FETCH, 1'b0, 32'h0000_1000, '0, 4'hf, CHK_READ, '0);
    add_entry(bus_pkg::MASTER_DATA, 1'b0, `SUBSYS_PERIPH_BASE + `SUBSYS_PERIPH_SPAN,
              '0, 4'hf, CHK_READ, '0);
    add_entry(bus_pkg::MASTER_DATA, 1'b1, STDOUT_ADR, 32'h41, 4'b0001, CHK_STDOUT, 32'h41);
    add_entry(bus_pkg::MASTER_DATA, 1'b0, STDOUT_ADR, '0, 4'hf, CHK_READ, '0);
    add_entry(bus_pkg::MASTER_DATA, 1'b1, EXIT_ADR, 32'h3, 4'hf, CHK_EXIT_FAIL, 32'h3);
    add_entry(bus_pkg::MASTER_DATA, 1'b0, EXIT_ADR, '0, 4'hf, CHK_READ, 32'h3);
    add_entry(bus_pkg::MASTER_DATA, 1'b0, '0, '0, 4'h0, CHK_RESET, '0);
    add_entry(bus_pkg::MASTER_DATA, 1'b1, EXIT_ADR, 32'h0, 4'hf, CHK_EXIT_PASS, 32'h0);
    add_entry(bus_pkg::MASTER_DATA, 1'b1, CMP_ADR, 32'd20, 4'hf, CHK_IRQ_SET, 32'd20);
    add_entry(bus_pkg::MASTER_DATA, 1'b0, CMP_ADR, '0, 4'hf, CHK_READ, 32'd20);
    add_entry(bus_pkg::MASTER_DATA, 1'b1, CMP_ADR, 32'h0, 4'hf, CHK_IRQ_CLEAR, '0);
  endtask

  task automatic apply_entry(input entry_t e);
    bus_pkg::data_t rd;
    int             waited;
    rd = '0;
    waited = 0;
    if (e.kind == CHK_RESET) begin
      @(posedge clk);
      #DRIVE_NS rerun_reset = 1'b1;
      repeat (2) @(posedge clk);
      #DRIVE_NS rerun_reset = 1'b0;
      @(negedge clk);
      check_flag("exit_valid after reset", exit_valid, 1'b0);
      check_flag("tests_failed after reset", tests_failed, 1'b0);
      check_flag("irq_timer after reset", irq_timer, 1'b0);
    end else begin
      if (e.port == bus_pkg::MASTER_FETCH) begin
        fetch_read(e.adr, rd);
      end else begin
        data_xfer(e.we, e.adr, e.dat, e.sel, rd);
      end
      case (e.kind)
        CHK_READ: begin
          check_word("read data", rd, e.exp);
          if (e.adr < 32'h1000) begin
            known_adr.push_back(e.adr);
            known_dat.push_back(e.exp);
          end
        end
        CHK_STDOUT: begin
          // the strobe lasts exactly one cycle
          @(negedge clk);
          check_flag("stdout_valid pulse", stdout_valid, 1'b1);
          check_word("stdout char", {24'h0, stdout_char}, e.exp);
          @(negedge clk);
          check_flag("stdout_valid after pulse", stdout_valid, 1'b0);
        end
        CHK_EXIT_FAIL, CHK_EXIT_PASS: begin
          @(negedge clk);
          check_flag("exit_valid", exit_valid, 1'b1);
          check_word("exit value", exit_value, e.exp);
          check_flag("tests_passed", tests_passed, e.kind == CHK_EXIT_PASS);
          check_flag("tests_failed", tests_failed, e.kind == CHK_EXIT_FAIL);
        end
        CHK_IRQ_SET: begin
          do begin
            @(negedge clk);
            waited++;
          end while (irq_timer !== 1'b1 && waited < int'(e.exp) + 8);
          check_flag("irq_timer raised", irq_timer, 1'b1);
        end
        CHK_IRQ_CLEAR: begin
          // the compare register changes first, the interrupt a cycle later
          @(negedge clk);
          check_flag("irq_timer before clear", irq_timer, 1'b1);
          @(negedge clk);
          check_flag("irq_timer cleared", irq_timer, 1'b0);
        end
        default: begin
        end
      endcase
    end
  endtask

  task automatic run_contention();
    bus_pkg::addr_t cont_adr[CONT_N];
    bus_pkg::data_t cont_dat[CONT_N];
    int             pick[2*CONT_N];
    bus_pkg::data_t rd_f;
    bus_pkg::data_t rd_d;
    int             errs_before;
    errs_before = error_count;
    // data port works in the upper half of the ram, away from the table words
    for (int i = 0; i < CONT_N; i++) begin
      cont_adr[i] = bus_pkg::addr_t'((32'd512 + take_bits(9)) << 2);
      cont_dat[i] = take_bits(32);
    end
    for (int i = 0; i < 2*CONT_N; i++) begin
      pick[i] = int'(take_bits(4)) % known_adr.size();
    end
    fork
      begin
        for (int i = 0; i < CONT_N; i++) begin
          data_xfer(1'b1, cont_adr[i], cont_dat[i], 4'hf, rd_d);
          data_xfer(1'b0, cont_adr[i], '0, 4'hf, rd_d);
          check_word("contention data read", rd_d, cont_dat[i]);
        end
      end
      begin
        for (int i = 0; i < 2*CONT_N; i++) begin
          fetch_read(known_adr[pick[i]], rd_f);
          check_word("contention fetch read", rd_f, known_dat[pick[i]]);
        end
      end
    join
    report_test("contention", errs_before);
  endtask

  // an ack must never reach a port that has no request open
  always @(negedge clk) begin
    if (reset === 1'b0) begin
      check_flag("fetch ack without request", fetch_ack & ~fetch_stb, 1'b0);
      check_flag("data ack without request", data_ack & ~data_stb, 1'b0);
    end
  end

  initial begin
    int errs_before;
    fetch_cyc   = 1'b0;
    fetch_stb   = 1'b0;
    fetch_adr   = '0;
    data_cyc    = 1'b0;
    data_stb    = 1'b0;
    data_we     = 1'b0;
    data_adr    = '0;
    data_dat_w  = '0;
    data_sel    = '0;
    rerun_reset = 1'b0;
    lfsr_q      = 32'hc5d49923;
    error_count = 0;
    test_count  = 0;
    bad_tests   = 0;
    build_table();
    watchdog_ns = longint'(table_q.size() + CONT_XFERS) * 10 * CLK_NS;
    fork
      begin
        #(watchdog_ns);
        $display("bus stalled: a transfer got no ack before the time limit ran out");
        $display("tests failed");
        $finish;
      end
    join_none
    while (reset !== 1'b0) @(posedge clk);
    foreach (table_q[i]) begin
      errs_before = error_count;
      apply_entry(table_q[i]);
      report_test(table_q[i].kind.name(), errs_before);
    end
    run_contention();
    $display("summary: %0d tests, %0d with errors, %0d error lines",
             test_count, bad_tests, error_count);
    if (error_count == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- build.f
+incdir+logic
logic/bus_pkg.sv
logic/periph_pkg.sv
logic/bus_interconnect.sv
logic/sim_ram.sv
logic/test_periph.sv
logic/mem_subsystem.sv
tests/tb_clock_gen.sv
tests/subsys_tb.sv
